/* vlog.f */
+incdir+logic
logic/u2_ctrl_pkg.sv
logic/misc_ctrl_regs.sv
logic/simple_timer.sv
logic/time_64bit.sv
logic/status_readback.sv
logic/u2_ctrl_top.sv
verif/u2_ctrl_tb.sv

/* verif/u2_ctrl_tb.sv */
//////////////////////////////
// DUT runs at 1000 ticks per second so seconds roll over quickly
// Internal state is only seen through the readback mux
//////////////////////////////
`include "u2_ctrl_macros.svh"

module u2_ctrl_tb
   import u2_ctrl_pkg::*;
();

   localparam int         TICKS       = 1000;
   // Well above the length of the test sequence
   localparam int         CYCLE_LIMIT = 6000;
   localparam logic [7:0] SW_LEDS     = 8'ha5;
   localparam logic [7:0] HW_BITS     = 8'h1e;

   logic          dsp_clk;
   logic          rst_i;
   set_bus_t      set_bus;
   board_status_t status;
   logic          pps_i;
   logic [3:0]    rb_addr;
   misc_ctrl_t    ctrl;
   logic [7:0]    leds;
   logic          irq;
   logic [31:0]   rb_data;

   int          value_errors = 0;
   int          wait_errors  = 0;
   int          cycle_cnt    = 0;
   logic        irq_quiet    = 1'b0;
   int          waited;
   misc_ctrl_t  exp_ctrl;
   logic [31:0] word;
   logic [31:0] secs_now;

   u2_ctrl_top #(
      .TICKS_PER_SEC (TICKS)
   ) DUT (
      .dsp_clk   (dsp_clk),
      .rst_i     (rst_i),
      .set_bus_i (set_bus),
      .status_i  (status),
      .pps_i     (pps_i),
      .rb_addr_i (rb_addr),
      .ctrl_o    (ctrl),
      .leds_o    (leds),
      .irq_o     (irq),
      .rb_data_o (rb_data)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #10 dsp_clk = ~dsp_clk;
   end

   always @(posedge dsp_clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt == CYCLE_LIMIT) begin
         $display("Run timed out after %0d cycles", CYCLE_LIMIT);
         $display("TESTS FAILED");
         $finish;
      end
   end

   task automatic log_error(input string msg);
      value_errors++;
      $display("** Error at time %0t: %s", $time, msg);
   endtask

   // Masked interrupts must never reach irq_o
   assert property (@(posedge dsp_clk) irq_quiet |-> irq === 1'b0)
      else log_error("irq_o high while the mask is 0");

   function automatic logic [7:0] hw_leds(input board_status_t s);
      hw_leds = {3'b000, s.run_tx, s.run_rx, s.clk_status, s.serdes_link_up, 1'b0};
   endfunction

   //////////////////////////////
   // Bus tasks
   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(posedge dsp_clk);
      #2;
      set_bus.stb  = 1'b1;
      set_bus.addr = addr;
      set_bus.data = data;
      @(posedge dsp_clk);
      #2;
      set_bus.stb = 1'b0;
   endtask

   task automatic read_word(input logic [3:0] addr, output logic [31:0] data);
      @(posedge dsp_clk);
      #2;
      rb_addr = addr;
      @(posedge dsp_clk);
      #2;
      data = rb_data;
   endtask

   task automatic check_ctrl(input misc_ctrl_t exp);
      assert (ctrl === exp) else log_error($sformatf("ctrl_o %h, expected %h", ctrl, exp));
   endtask

   task automatic wait_irq_level(input logic level, input int max_cycles, output int cycles);
      cycles = 0;
      while (irq !== level && cycles < max_cycles) begin
         @(posedge dsp_clk);
         #2;
         cycles++;
      end
      if (irq !== level) begin
         wait_errors++;
         $display("irq_o did not go to %0b within %0d cycles", level, max_cycles);
      end
   endtask

   // Holds the pending word on the readback port and polls one bit
   task automatic wait_pending_bit(input int bit_idx, input int max_cycles);
      int cycles;
      cycles  = 0;
      rb_addr = 4'd5;
      do begin
         @(posedge dsp_clk);
         #2;
         cycles++;
      end while (!rb_data[bit_idx] && cycles < max_cycles);
      if (!rb_data[bit_idx]) begin
         wait_errors++;
         $display("Pending bit %0d was not set within %0d cycles", bit_idx, max_cycles);
      end
   endtask

   //////////////////////////////
   // Test sequence
   initial begin
      rst_i   = 1'b1;
      set_bus = '0;
      status  = '0;
      pps_i   = 1'b0;
      rb_addr = '0;
      repeat (10) @(posedge dsp_clk);
      #2 rst_i = 1'b0;

      // Reset values and compat number
      exp_ctrl = '0;
      exp_ctrl.phy_resetn = 1'b1;
      check_ctrl(exp_ctrl);
      read_word(4'd0, word);
      assert (word == 32'd5) else log_error($sformatf("compat word %0d, expected 5", word));

      // Misc registers, clock word is {clock_ready, clk_en, clk_sel}
      write_setting(`U2_SR_MISC + 0, 32'h16);
      exp_ctrl.clock_ready = 1'b1;
      exp_ctrl.clk_en      = 2'b01;
      exp_ctrl.clk_sel     = 2'b10;
      check_ctrl(exp_ctrl);
      write_setting(`U2_SR_MISC + 1, 32'ha);
      exp_ctrl.ser_enable = 1'b1;
      exp_ctrl.ser_loopen = 1'b1;
      check_ctrl(exp_ctrl);
      write_setting(`U2_SR_MISC + 2, 32'h6);
      exp_ctrl.adc_on_a = 1'b1;
      exp_ctrl.adc_oe_b = 1'b1;
      check_ctrl(exp_ctrl);
      write_setting(`U2_SR_MISC + 4, 32'h1);
      exp_ctrl.phy_resetn = 1'b0;
      check_ctrl(exp_ctrl);
      write_setting(`U2_SR_MISC + 4, 32'h0);
      exp_ctrl.phy_resetn = 1'b1;
      check_ctrl(exp_ctrl);

      // LED mux, hardware on bits 1 to 4 out of reset
      write_setting(`U2_SR_MISC + 3, SW_LEDS);
      for (int i = 0; i < 16; i++) begin
         @(posedge dsp_clk);
         #2;
         status = board_status_t'(i);
         #1;
         assert (leds === ((hw_leds(status) & HW_BITS) | (SW_LEDS & ~HW_BITS)))
            else log_error($sformatf("leds_o %h with status %h", leds, status));
      end
      write_setting(`U2_SR_MISC + 6, 32'h0);
      for (int i = 0; i < 16; i++) begin
         @(posedge dsp_clk);
         #2;
         status = board_status_t'(i);
         #1;
         assert (leds === SW_LEDS) else log_error($sformatf("leds_o %h, expected sw", leds));
      end

      // VITA time load and rollover
      write_setting(`U2_SR_TIME64 + 0, 32'd7);
      write_setting(`U2_SR_TIME64 + 1, 32'd990);
      repeat (20) @(posedge dsp_clk);
      #2;
      read_word(4'd1, word);
      assert (word == 32'd8) else log_error($sformatf("secs %0d, expected 8", word));
      read_word(4'd2, word);
      assert (word < TICKS) else log_error($sformatf("ticks %0d out of range", word));

      // PPS capture
      pps_i = 1'b1;
      wait_pending_bit(0, 6);
      read_word(4'd1, secs_now);
      read_word(4'd3, word);
      assert (word == secs_now) else log_error($sformatf("PPS secs %0d, now %0d", word, secs_now));
      pps_i = 1'b0;

      // One-shot through the mask to irq_o
      write_setting(`U2_SR_IRQ + 1, 32'hff);
      write_setting(`U2_SR_IRQ + 0, 32'h07);
      write_setting(`U2_SR_SIMTIMER + 0, 32'd50);
      wait_irq_level(1'b1, 60, waited);
      assert (waited >= 49 && waited <= 52)
         else log_error($sformatf("irq_o rose %0d cycles after the one-shot write", waited));
      read_word(4'd5, word);
      assert (word[1]) else log_error("one-shot pending bit not set");
      write_setting(`U2_SR_IRQ + 1, 32'h2);
      wait_irq_level(1'b0, 3, waited);

      // Periodic with everything masked
      write_setting(`U2_SR_IRQ + 0, 32'h0);
      repeat (2) @(posedge dsp_clk);
      #2 irq_quiet = 1'b1;
      write_setting(`U2_SR_SIMTIMER + 1, 32'd100);
      repeat (3) begin
         wait_pending_bit(2, 110);
         write_setting(`U2_SR_IRQ + 1, 32'h4);
         read_word(4'd5, word);
         assert (!word[2]) else log_error("periodic pending bit did not clear");
      end
      write_setting(`U2_SR_SIMTIMER + 1, 32'd0);
      irq_quiet = 1'b0;

      $display("Value errors: %0d, wait errors: %0d", value_errors, wait_errors);
      if (value_errors + wait_errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

/* logic/u2_ctrl_top.sv */
//////////////////////////////
// Radio core control plane, single dsp_clk domain
// Settings writes have no handshake and are never stalled
//////////////////////////////
`include "u2_ctrl_macros.svh"

module u2_ctrl_top
   import u2_ctrl_pkg::*;
#(
   parameter int unsigned TICKS_PER_SEC = `U2_TICKS_PER_SEC
) (
   input  logic                  dsp_clk,
   input  logic                  rst_i,
   input  set_bus_t              set_bus_i,
   input  board_status_t         status_i,
   input  logic                  pps_i,
   input  logic [`U2_RB_AW-1:0]  rb_addr_i,
   output misc_ctrl_t            ctrl_o,
   output logic [7:0]            leds_o,
   output logic                  irq_o,
   output logic [`U2_SET_DW-1:0] rb_data_o
);

   logic       onetime_int;
   logic       periodic_int;
   logic       pps_int;
   vita_time_t vita_time;
   vita_time_t vita_pps;

   //////////////////////////////
   // Board control and LEDs
   misc_ctrl_regs u_misc (
      .dsp_clk   (dsp_clk),
      .rst_i     (rst_i),
      .set_bus_i (set_bus_i),
      .status_i  (status_i),
      .ctrl_o    (ctrl_o),
      .leds_o    (leds_o)
   );

   //////////////////////////////
   // Timers
   simple_timer u_timer (
      .dsp_clk        (dsp_clk),
      .rst_i          (rst_i),
      .set_bus_i      (set_bus_i),
      .onetime_int_o  (onetime_int),
      .periodic_int_o (periodic_int)
   );

   time_64bit #(
      .TICKS_PER_SEC (TICKS_PER_SEC)
   ) u_time (
      .dsp_clk     (dsp_clk),
      .rst_i       (rst_i),
      .set_bus_i   (set_bus_i),
      .pps_i       (pps_i),
      .vita_time_o (vita_time),
      .vita_pps_o  (vita_pps),
      .pps_int_o   (pps_int)
   );

   //////////////////////////////
   // Interrupts and readback
   status_readback u_status (
      .dsp_clk        (dsp_clk),
      .rst_i          (rst_i),
      .set_bus_i      (set_bus_i),
      .pps_int_i      (pps_int),
      .onetime_int_i  (onetime_int),
      .periodic_int_i (periodic_int),
      .vita_time_i    (vita_time),
      .vita_pps_i     (vita_pps),
      .rb_addr_i      (rb_addr_i),
      .irq_o          (irq_o),
      .rb_data_o      (rb_data_o)
   );

endmodule

/* logic/status_readback.sv */
//////////////////////////////
// Pending bits stay set until cleared by a settings write
// Readback is one cycle behind rb_addr_i
//////////////////////////////
`include "u2_ctrl_macros.svh"

module status_readback
   import u2_ctrl_pkg::*;
(
   input  logic                  dsp_clk,
   input  logic                  rst_i,
   input  set_bus_t              set_bus_i,
   input  logic                  pps_int_i,
   input  logic                  onetime_int_i,
   input  logic                  periodic_int_i,
   input  vita_time_t            vita_time_i,
   input  vita_time_t            vita_pps_i,
   input  logic [`U2_RB_AW-1:0]  rb_addr_i,
   output logic                  irq_o,
   output logic [`U2_SET_DW-1:0] rb_data_o
);

   localparam logic [`U2_SET_AW-1:0] ADDR_MASK  = `U2_SR_IRQ + 0;
   localparam logic [`U2_SET_AW-1:0] ADDR_CLEAR = `U2_SR_IRQ + 1;
   localparam int                    PAD_W      = `U2_SET_DW - `U2_IRQ_W;

   irq_t irq_new;
   irq_t irq_clr;
   irq_t pending;
   irq_t mask;

   always_comb begin
      irq_new          = '0;
      irq_new.pps      = pps_int_i;
      irq_new.onetime  = onetime_int_i;
      irq_new.periodic = periodic_int_i;
   end

   assign irq_clr = (set_bus_i.stb && (set_bus_i.addr == ADDR_CLEAR)) ?
                    set_bus_i.data[`U2_IRQ_W-1:0] : '0;

   //////////////////////////////
   // Interrupt latch
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         pending <= '0;
         mask    <= '0;
         irq_o   <= 1'b0;
      end else begin
         // New events win over a clear in the same cycle
         pending <= (pending & ~irq_clr) | irq_new;
         if (set_bus_i.stb && (set_bus_i.addr == ADDR_MASK))
            mask <= set_bus_i.data[`U2_IRQ_W-1:0];
         irq_o <= |(pending & mask);
      end
   end

   //////////////////////////////
   // Readback mux
   always_ff @(posedge dsp_clk) begin
      case (rb_addr_i)
         4'd0:    rb_data_o <= `U2_COMPAT_NUM;
         4'd1:    rb_data_o <= vita_time_i.f.secs;
         4'd2:    rb_data_o <= vita_time_i.f.ticks;
         4'd3:    rb_data_o <= vita_pps_i.f.secs;
         4'd4:    rb_data_o <= vita_pps_i.f.ticks;
         4'd5:    rb_data_o <= {{PAD_W{1'b0}}, pending};
         4'd6:    rb_data_o <= {{PAD_W{1'b0}}, mask};
         default: rb_data_o <= '0;
      endcase
   end

endmodule

/* logic/time_64bit.sv */
//////////////////////////////
// Seconds only advance on tick rollover, TICKS_PER_SEC must exceed 1
// pps_i is asynchronous and goes through two flops first
//////////////////////////////
`include "u2_ctrl_macros.svh"

module time_64bit
   import u2_ctrl_pkg::*;
#(
   parameter int unsigned TICKS_PER_SEC = `U2_TICKS_PER_SEC
) (
   input  logic       dsp_clk,
   input  logic       rst_i,
   input  set_bus_t   set_bus_i,
   input  logic       pps_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_pps_o,
   output logic       pps_int_o
);

   localparam logic [`U2_SET_AW-1:0] ADDR_SECS  = `U2_SR_TIME64 + 0;
   localparam logic [`U2_SET_AW-1:0] ADDR_TICKS = `U2_SR_TIME64 + 1;
   localparam logic [31:0]           LAST_TICK  = TICKS_PER_SEC - 1;

   logic        wr_secs;
   logic        wr_ticks;
   logic [31:0] secs_hold;
   logic [1:0]  pps_sync;
   logic        pps_prev;
   logic        pps_rise;

   assign wr_secs  = set_bus_i.stb && (set_bus_i.addr == ADDR_SECS);
   assign wr_ticks = set_bus_i.stb && (set_bus_i.addr == ADDR_TICKS);

   // Seconds wait here until the ticks write
   always_ff @(posedge dsp_clk) begin
      if (wr_secs)
         secs_hold <= set_bus_i.data;
   end

   //////////////////////////////
   // Time counter
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         vita_time_o.raw <= '0;
      end else if (wr_ticks) begin
         vita_time_o.f.secs  <= secs_hold;
         vita_time_o.f.ticks <= set_bus_i.data;
      end else if (vita_time_o.f.ticks == LAST_TICK) begin
         vita_time_o.f.ticks <= '0;
         vita_time_o.f.secs  <= vita_time_o.f.secs + 1'b1;
      end else begin
         vita_time_o.f.ticks <= vita_time_o.f.ticks + 1'b1;
      end
   end

   //////////////////////////////
   // PPS synchronizer and edge detect
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         pps_sync  <= '0;
         pps_prev  <= 1'b0;
         pps_int_o <= 1'b0;
      end else begin
         pps_sync  <= {pps_sync[0], pps_i};
         pps_prev  <= pps_sync[1];
         pps_int_o <= pps_rise;
      end
   end

   assign pps_rise = pps_sync[1] & ~pps_prev;

   // Snapshot lands with the interrupt pulse
   always_ff @(posedge dsp_clk) begin
      if (pps_rise)
         vita_pps_o.raw <= vita_time_o.raw;
   end

endmodule

/* logic/simple_timer.sv */
//////////////////////////////
// Countdowns in dsp_clk cycles, a write of 0 stops a timer
// A new write restarts the count from the written value
//////////////////////////////
`include "u2_ctrl_macros.svh"

module simple_timer
   import u2_ctrl_pkg::*;
(
   input  logic     dsp_clk,
   input  logic     rst_i,
   input  set_bus_t set_bus_i,
   output logic     onetime_int_o,
   output logic     periodic_int_o
);

   localparam logic [`U2_SET_AW-1:0] ADDR_ONETIME  = `U2_SR_SIMTIMER + 0;
   localparam logic [`U2_SET_AW-1:0] ADDR_PERIODIC = `U2_SR_SIMTIMER + 1;

   logic                  wr_onetime;
   logic                  wr_periodic;
   logic [`U2_SET_DW-1:0] onetime_cnt;
   logic [`U2_SET_DW-1:0] period;
   logic [`U2_SET_DW-1:0] periodic_cnt;

   assign wr_onetime  = set_bus_i.stb && (set_bus_i.addr == ADDR_ONETIME);
   assign wr_periodic = set_bus_i.stb && (set_bus_i.addr == ADDR_PERIODIC);

   //////////////////////////////
   // One-shot, fires when the count leaves 1
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         onetime_cnt   <= '0;
         onetime_int_o <= 1'b0;
      end else begin
         onetime_int_o <= !wr_onetime && (onetime_cnt == 1);
         if (wr_onetime)
            onetime_cnt <= set_bus_i.data;
         else if (onetime_cnt != 0)
            onetime_cnt <= onetime_cnt - 1'b1;
      end
   end

   //////////////////////////////
   // Periodic, reloads from the stored period
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         period         <= '0;
         periodic_cnt   <= '0;
         periodic_int_o <= 1'b0;
      end else begin
         periodic_int_o <= !wr_periodic && (period != 0) && (periodic_cnt == 1);
         if (wr_periodic) begin
            period       <= set_bus_i.data;
            periodic_cnt <= set_bus_i.data;
         end else if (period != 0) begin
            periodic_cnt <= (periodic_cnt == 1) ? period : periodic_cnt - 1'b1;
         end
      end
   end

endmodule

/* logic/misc_ctrl_regs.sv */
//////////////////////////////
// Misc board control registers and LED source select
// LED bits with led_src set follow status_i with no register
//////////////////////////////
`include "u2_ctrl_macros.svh"

module misc_ctrl_regs
   import u2_ctrl_pkg::*;
(
   input  logic          dsp_clk,
   input  logic          rst_i,
   input  set_bus_t      set_bus_i,
   input  board_status_t status_i,
   output misc_ctrl_t    ctrl_o,
   output logic [7:0]    leds_o
);

   localparam logic [`U2_SET_AW-1:0] ADDR_CLK     = `U2_SR_MISC + 0;
   localparam logic [`U2_SET_AW-1:0] ADDR_SER     = `U2_SR_MISC + 1;
   localparam logic [`U2_SET_AW-1:0] ADDR_ADC     = `U2_SR_MISC + 2;
   localparam logic [`U2_SET_AW-1:0] ADDR_LED_SW  = `U2_SR_MISC + 3;
   localparam logic [`U2_SET_AW-1:0] ADDR_PHY     = `U2_SR_MISC + 4;
   localparam logic [`U2_SET_AW-1:0] ADDR_LED_SRC = `U2_SR_MISC + 6;

   logic [4:0] clk_reg;
   logic [3:0] ser_reg;
   logic [3:0] adc_reg;
   logic [7:0] led_sw;
   logic [7:0] led_src;
   logic       phy_reset;
   logic [7:0] led_hw;

   //////////////////////////////
   // Setting registers
   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         clk_reg   <= '0;
         ser_reg   <= '0;
         adc_reg   <= '0;
         led_sw    <= '0;
         led_src   <= `U2_LED_SRC_RST;
         phy_reset <= 1'b0;
      end else if (set_bus_i.stb) begin
         case (set_bus_i.addr)
            ADDR_CLK:     clk_reg   <= set_bus_i.data[4:0];
            ADDR_SER:     ser_reg   <= set_bus_i.data[3:0];
            ADDR_ADC:     adc_reg   <= set_bus_i.data[3:0];
            ADDR_LED_SW:  led_sw    <= set_bus_i.data[7:0];
            ADDR_PHY:     phy_reset <= set_bus_i.data[0];
            ADDR_LED_SRC: led_src   <= set_bus_i.data[7:0];
            default: ;
         endcase
      end
   end

   // Field order matches the register bits, top field in the high bit
   always_comb begin
      {ctrl_o.clock_ready, ctrl_o.clk_en, ctrl_o.clk_sel} = clk_reg;
      {ctrl_o.ser_enable, ctrl_o.ser_prbsen, ctrl_o.ser_loopen, ctrl_o.ser_rx_en} = ser_reg;
      {ctrl_o.adc_oe_a, ctrl_o.adc_on_a, ctrl_o.adc_oe_b, ctrl_o.adc_on_b} = adc_reg;
      // PHY reset pin is active low
      ctrl_o.phy_resetn = ~phy_reset;
   end

   //////////////////////////////
   // LED select, 1 = hardware, 0 = software
   assign led_hw = {3'b000, status_i.run_tx, status_i.run_rx,
                    status_i.clk_status, status_i.serdes_link_up, 1'b0};

   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

/* logic/u2_ctrl_pkg.sv */
//////////////////////////////
// Shared types of the control plane, all on dsp_clk
//////////////////////////////
`include "u2_ctrl_macros.svh"

package u2_ctrl_pkg;

   // One settings write, strobe is a single-cycle pulse
   typedef struct packed {
      logic                  stb;
      logic [`U2_SET_AW-1:0] addr;
      logic [`U2_SET_DW-1:0] data;
   } set_bus_t;

   // Hardware status pins
   typedef struct packed {
      logic run_tx;
      logic run_rx;
      logic clk_status;
      logic serdes_link_up;
   } board_status_t;

   // Board control outputs
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
      logic       phy_resetn;
   } misc_ctrl_t;

   typedef struct packed {
      logic [31:0] secs;
      logic [31:0] ticks;
   } vita_fields_t;

   // Raw count for snapshots, split view for rollover and readback
   typedef union packed {
      logic [63:0]  raw;
      vita_fields_t f;
   } vita_time_t;

   // Interrupt vector, pps is bit 0
   typedef struct packed {
      logic [`U2_IRQ_W-4:0] rsvd;
      logic                 periodic;
      logic                 onetime;
      logic                 pps;
   } irq_t;

endpackage

/* logic/u2_ctrl_macros.svh */
//////////////////////////////
// Settings addresses are word addresses on the 8-bit settings bus
// Widths here must agree with the types in the package
//////////////////////////////
`ifndef U2_CTRL_MACROS_SVH
`define U2_CTRL_MACROS_SVH

// Settings bus register bases
`define U2_SR_MISC        0
`define U2_SR_SIMTIMER    8
`define U2_SR_TIME64      10
`define U2_SR_IRQ         20

// Bus and vector widths
`define U2_SET_AW         8
`define U2_SET_DW         32
`define U2_IRQ_W          8
`define U2_RB_AW          4

// Bump when the register map changes
`define U2_COMPAT_NUM     32'd5

// LEDs 1 to 4 show hardware status out of reset
`define U2_LED_SRC_RST    8'b0001_1110

// Default dsp_clk rate in ticks per second
`define U2_TICKS_PER_SEC  100000000

`endif
